/* Makefile */
# Verilator build and run for the host bus front end

VERILATOR ?= verilator
TOP       ?= xv_host_bus_tb
FILELIST  ?= xv_host_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@grep -q "^RESULT: PASS$$" $(LOG) || { echo "pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/xv_host_bus_checker.sv */
`timescale 1ns/1ps

module xv_host_bus_checker (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire logic write_strobe_i,
    input  wire logic read_strobe_i,
    input  wire logic reg_wr_i,
    input  wire logic reg_busy_i,
    input  wire logic overflow_i
);

    // one command per access, never both kinds at once
    strobes_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(write_strobe_i && read_strobe_i))
        else $error("write and read strobe high together");

    write_strobe_single: assert property (@(posedge clk) disable iff (reset_i)
        write_strobe_i |=> !write_strobe_i)
        else $error("write strobe longer than one cycle");

    read_strobe_single: assert property (@(posedge clk) disable iff (reset_i)
        read_strobe_i |=> !read_strobe_i)
        else $error("read strobe longer than one cycle");

    // busy holds the write port off completely
    no_write_while_busy: assert property (@(posedge clk) disable iff (reset_i)
        !(reg_wr_i && reg_busy_i))
        else $error("reg_wr_o high while reg_busy_i high");

    overflow_sticky: assert property (@(posedge clk) disable iff (reset_i)
        $fell(overflow_i) |-> $past(reset_i))
        else $error("overflow_o cleared outside reset");

endmodule

bind xv_host_bus xv_host_bus_checker checker0 (
    .clk            (clk),
    .reset_i        (reset_i),
    .write_strobe_i (write_strobe),   // internal strobes of the top level
    .read_strobe_i  (read_strobe),
    .reg_wr_i       (reg_wr_o),
    .reg_busy_i     (reg_busy_i),
    .overflow_i     (overflow_o)
);

/* sim/xv_host_bus_tb.sv */
`timescale 1ns/1ps

module xv_host_bus_tb;

    localparam int NUM_TESTS  = 6;
    localparam int HOLD_CYC   = 4;       // chip select low, then high, this long
    localparam int READ_WAIT  = 12;      // release to rd_data_o sample
    localparam int PULSE_WAIT = 60;      // limit when draining queued writes
    localparam int ENTRY_W    = xv_bus_pkg::REG_NUM_W + xv_reg_pkg::WORD_W;

    logic                             clk;
    logic                             reset;
    logic                             bus_cs_n;
    logic                             bus_rd_nwr;
    logic [xv_bus_pkg::REG_NUM_W-1:0] bus_reg_num;
    logic                             bus_bytesel;
    logic [xv_bus_pkg::BYTE_W-1:0]    bus_data;
    logic                             reg_busy;
    logic                             reg_wr;
    logic [xv_bus_pkg::REG_NUM_W-1:0] reg_addr;
    logic [xv_reg_pkg::WORD_W-1:0]    reg_wdata;
    logic [xv_bus_pkg::BYTE_W-1:0]    rd_data;
    logic                             overflow;

    // reference model of the register set
    logic [xv_reg_pkg::WORD_W-1:0] model_regs [xv_reg_pkg::NUM_REGS];
    logic [xv_bus_pkg::BYTE_W-1:0] model_latch;
    logic [ENTRY_W-1:0]            expected_writes [$];   // {addr, word}, issue order

    logic [31:0] lfsr_state;
    int          error_count;
    int          tests_run;
    int          pulse_count;

    xv_host_bus dut0 (
        .bus_cs_n_i    (bus_cs_n),
        .bus_rd_nwr_i  (bus_rd_nwr),
        .bus_reg_num_i (bus_reg_num),
        .bus_bytesel_i (bus_bytesel),
        .bus_data_i    (bus_data),
        .reg_busy_i    (reg_busy),
        .reg_wr_o      (reg_wr),
        .reg_addr_o    (reg_addr),
        .reg_wdata_o   (reg_wdata),
        .rd_data_o     (rd_data),
        .overflow_o    (overflow),
        .clk           (clk),
        .reset_i       (reset)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b          = {b[6:0], lfsr_state[0]};    // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("ERROR %s: got %0h expected %0h at %0t", name, got, exp, $time);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("failure: %s at %0t", what, $time);
    endtask

    task automatic finish_test(input string name, input int first_error);
        tests_run++;
        if (error_count == first_error) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, error_count - first_error);
    endtask

    // every write pulse must match the oldest outstanding expectation
    // sampled at the rising edge that takes the pulse
    always @(posedge clk) begin : write_monitor
        logic [ENTRY_W-1:0] entry;
        if (!reset && reg_wr) begin
            pulse_count++;
            if (expected_writes.size() == 0) begin
                report_failure($sformatf("unexpected write pulse to register %0d", reg_addr));
            end else begin
                entry = expected_writes.pop_front();
                if (reg_addr !== entry[xv_reg_pkg::WORD_W +: xv_bus_pkg::REG_NUM_W])
                    report_mismatch("reg_addr_o", 32'(reg_addr), 32'(entry[ENTRY_W-1 -: 4]));
                if (reg_wdata !== entry[xv_reg_pkg::WORD_W-1:0])
                    report_mismatch("reg_wdata_o", 32'(reg_wdata), 32'(entry[15:0]));
            end
        end
    end

    // one host access, chip select held then released
    task automatic bus_access(input logic is_read, input logic [3:0] num, input logic sel,
                              input logic [7:0] data);
        @(negedge clk);
        bus_cs_n    = xv_bus_pkg::CS_ENABLED;
        bus_rd_nwr  = is_read ? xv_bus_pkg::RNW_READ : !xv_bus_pkg::RNW_READ;
        bus_reg_num = num;
        bus_bytesel = sel;
        bus_data    = data;
        repeat (HOLD_CYC) @(negedge clk);
        bus_cs_n = !xv_bus_pkg::CS_ENABLED;     // fields stay put after release
    endtask

    // keep low means the queue is expected to drop this access
    task automatic host_write(input logic [3:0] num, input logic sel, input logic [7:0] data,
                              input logic keep);
        logic [xv_reg_pkg::WORD_W-1:0] word;
        if (keep && !sel) begin
            model_latch = data;                 // even byte only latches
        end else if (keep) begin
            word = {model_latch, data};
            model_regs[num] = word;
            expected_writes.push_back({num, word});
        end
        bus_access(1'b0, num, sel, data);
        repeat (HOLD_CYC) @(negedge clk);
    endtask

    task automatic host_read(input logic [3:0] num, input logic sel);
        logic [7:0] exp;
        exp = sel ? model_regs[num][7:0] : model_regs[num][15:8];
        bus_access(1'b1, num, sel, 8'h00);
        repeat (READ_WAIT) @(negedge clk);
        if (rd_data !== exp) report_mismatch("rd_data_o", 32'(rd_data), 32'(exp));
    endtask

    task automatic wait_for_writes();
        int n;
        n = 0;
        while (expected_writes.size() != 0 && n < PULSE_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (expected_writes.size() != 0) begin
            report_failure($sformatf("%0d write pulses never came", expected_writes.size()));
            expected_writes.delete();
        end
    endtask

    task automatic test_reset_state();
        int first_error;
        first_error = error_count;
        if (reg_wr !== 1'b0) report_mismatch("reg_wr_o", 32'(reg_wr), 0);
        if (overflow !== 1'b0) report_mismatch("overflow_o", 32'(overflow), 0);
        for (int r = 0; r < xv_reg_pkg::NUM_REGS; r++) begin
            host_read(r[3:0], 1'b0);
            host_read(r[3:0], 1'b1);
        end
        finish_test("reset_state", first_error);
    endtask

    task automatic test_word_write();
        int         first_error;
        int         start_pulses;
        logic [7:0] hi;
        logic [7:0] lo;
        first_error  = error_count;
        start_pulses = pulse_count;
        random_byte(hi);
        random_byte(lo);
        host_write(4'd3, 1'b0, hi, 1'b1);
        repeat (8) @(negedge clk);
        if (pulse_count != start_pulses) report_failure("even write alone gave a write pulse");
        host_write(4'd3, 1'b1, lo, 1'b1);
        wait_for_writes();
        if (pulse_count != start_pulses + 1) report_failure("word write pulse count wrong");
        finish_test("word_write", first_error);
    endtask

    task automatic test_readback();
        int         first_error;
        logic [7:0] lo;
        first_error = error_count;
        host_read(4'd3, 1'b0);
        host_read(4'd3, 1'b1);
        random_byte(lo);
        host_write(4'd9, 1'b1, lo, 1'b1);      // high byte from the held latch
        wait_for_writes();
        host_read(4'd9, 1'b0);
        host_read(4'd9, 1'b1);
        finish_test("readback", first_error);
    endtask

    task automatic test_ordering();
        int         first_error;
        logic [7:0] hi;
        logic [7:0] lo;
        first_error = error_count;
        random_byte(hi);
        random_byte(lo);
        @(negedge clk);
        reg_busy = 1'b1;                       // word write waits at the head
        host_write(4'd12, 1'b0, hi, 1'b1);
        host_write(4'd12, 1'b1, lo, 1'b1);
        fork
            host_read(4'd12, 1'b1);            // queued right behind the write
            begin
                repeat (2 * HOLD_CYC) @(negedge clk);
                reg_busy = 1'b0;               // write drains first, then the read
            end
        join
        host_read(4'd12, 1'b0);
        wait_for_writes();
        finish_test("ordering", first_error);
    endtask

    task automatic test_back_pressure();
        int         first_error;
        int         start_pulses;
        logic [7:0] b;
        first_error  = error_count;
        start_pulses = pulse_count;
        @(negedge clk);
        reg_busy = 1'b1;
        for (int w = 0; w < 4; w++) begin      // two words, registers 5 and 6
            random_byte(b);
            host_write(4'(5 + w / 2), w[0], b, 1'b1);
        end
        repeat (8) @(negedge clk);
        if (pulse_count != start_pulses) report_failure("write pulse while busy");
        reg_busy = 1'b0;
        wait_for_writes();
        if (pulse_count != start_pulses + 2) report_failure("pulse count after release wrong");
        if (overflow !== 1'b0) report_mismatch("overflow_o", 32'(overflow), 0);
        finish_test("back_pressure", first_error);
    endtask

    task automatic test_overflow();
        int         first_error;
        logic [7:0] b;
        first_error = error_count;
        @(negedge clk);
        reg_busy = 1'b1;
        random_byte(b);
        host_write(4'd0, 1'b0, b, 1'b1);       // popped at once, latch only
        for (int w = 0; w < xv_reg_pkg::FIFO_DEPTH + 2; w++) begin
            random_byte(b);
            host_write(4'(10 + w), 1'b1, b, w < xv_reg_pkg::FIFO_DEPTH);
        end
        if (overflow !== 1'b1) report_mismatch("overflow_o", 32'(overflow), 1);
        reg_busy = 1'b0;
        wait_for_writes();
        for (int r = 10; r < 10 + xv_reg_pkg::FIFO_DEPTH + 2; r++) begin
            host_read(r[3:0], 1'b0);           // dropped ones keep old values
            host_read(r[3:0], 1'b1);
        end
        if (overflow !== 1'b1) report_mismatch("overflow_o", 32'(overflow), 1);
        finish_test("overflow", first_error);
    endtask

    // watchdog, generous per test budget
    initial begin
        repeat (NUM_TESTS * 400) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * 400);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        lfsr_state  = 32'h9350;
        error_count = 0;
        tests_run   = 0;
        pulse_count = 0;
        model_latch = '0;
        for (int r = 0; r < xv_reg_pkg::NUM_REGS; r++) model_regs[r] = '0;
        bus_cs_n    = !xv_bus_pkg::CS_ENABLED;
        bus_rd_nwr  = !xv_bus_pkg::RNW_READ;
        bus_reg_num = '0;
        bus_bytesel = 1'b0;
        bus_data    = '0;
        reg_busy    = 1'b0;
        reset       = 1'b1;
        repeat (2) @(negedge clk);              // two rising edges in reset
        reset = 1'b0;
        test_reset_state();
        test_word_write();
        test_readback();
        test_ordering();
        test_back_pressure();
        test_overflow();
        $display("tests %0d, write pulses %0d, errors %0d", tests_run, pulse_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/bus_cmd_fifo.sv */
`timescale 1ns/1ps

module bus_cmd_fifo (
    input  wire logic                             push_i,       // one command per strobe
    input  wire logic [xv_reg_pkg::CMD_W-1:0]     push_data_i,
    input  wire logic                             pop_i,        // consumer takes the head
    output logic      [xv_reg_pkg::CMD_W-1:0]     head_o,       // oldest entry
    output logic                                  empty_o,
    output logic                                  overflow_o,   // sticky until reset
    input  wire logic                             clk,
    input  wire logic                             reset_i
);

    // count needs one bit more than the pointers to tell full from empty
    localparam int CNT_W = xv_reg_pkg::FIFO_PTR_W + 1;
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(xv_reg_pkg::FIFO_DEPTH);

    logic [xv_reg_pkg::CMD_W-1:0]      mem_r [xv_reg_pkg::FIFO_DEPTH];   // entry storage
    logic [xv_reg_pkg::FIFO_PTR_W-1:0] wr_ptr_r;     // next free slot
    logic [xv_reg_pkg::FIFO_PTR_W-1:0] rd_ptr_r;     // head slot
    logic [CNT_W-1:0]                  count_r;      // entries held

    logic full;
    logic do_push;
    logic do_pop;

    assign full    = (count_r == FULL_CNT);
    assign do_push = push_i && !full;         // full drops the command
    assign do_pop  = pop_i && !empty_o;       // guard against a stray pop

    assign empty_o = (count_r == '0);
    assign head_o  = mem_r[rd_ptr_r];         // shown combinationally

    // storage, written only on an accepted push
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_r[wr_ptr_r] <= push_data_i;
        end
    end

    // pointers, occupancy and overflow flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_r   <= '0;
            rd_ptr_r   <= '0;
            count_r    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;      // wraps at FIFO_DEPTH
            end
            if (do_pop) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            // push and pop in one cycle leave the count alone
            case ({do_push, do_pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
            if (push_i && full) begin
                overflow_o <= 1'b1;               // lost access, stays set
            end
        end
    end

endmodule

/* verilog/bus_interface.sv */
`timescale 1ns/1ps

module bus_interface (
    // asynchronous host bus
    input  wire logic                                 bus_cs_n_i,      // select, active low
    input  wire logic                                 bus_rd_nwr_i,    // 1 read, 0 write
    input  wire logic [xv_bus_pkg::REG_NUM_W-1:0]     bus_reg_num_i,   // register number
    input  wire logic                                 bus_bytesel_i,   // 0 even, 1 odd byte
    input  wire logic [xv_bus_pkg::BYTE_W-1:0]        bus_data_i,      // write data byte
    // strobes and fields toward the queue
    output logic                                      write_strobe_o,  // one cycle per write
    output logic                                      read_strobe_o,   // one cycle per read
    output logic [xv_bus_pkg::REG_NUM_W-1:0]          reg_num_o,
    output logic                                      bytesel_o,
    output logic [xv_bus_pkg::BYTE_W-1:0]             bytedata_o,
    input  wire logic                                 clk,
    input  wire logic                                 reset_i
);

    // selected history, newest sample enters at bit 3 and moves right
    logic [3:0] cs_hist_r;

    // data field synchronizers, element 0 is the settled one
    logic [xv_bus_pkg::SYNC_STAGES-1:0] read_r;
    logic [xv_bus_pkg::SYNC_STAGES-1:0] bytesel_r;
    logic [xv_bus_pkg::REG_NUM_W-1:0]   reg_num_r [xv_bus_pkg::SYNC_STAGES];
    logic [xv_bus_pkg::BYTE_W-1:0]      data_r    [xv_bus_pkg::SYNC_STAGES];

    logic cs_rise;      // selected for two samples after being idle

    // two selected samples behind an idle one, so a single sample glitch never fires
    assign cs_rise = (cs_hist_r[2:0] == 3'b110);

    // field synchronizers, free running
    always_ff @(posedge clk) begin
        read_r    <= {(bus_rd_nwr_i == xv_bus_pkg::RNW_READ),
                      read_r[xv_bus_pkg::SYNC_STAGES-1:1]};
        bytesel_r <= {bus_bytesel_i, bytesel_r[xv_bus_pkg::SYNC_STAGES-1:1]};
        for (int i = 0; i < xv_bus_pkg::SYNC_STAGES - 1; i++) begin
            reg_num_r[i] <= reg_num_r[i+1];     // shift toward element 0
            data_r[i]    <= data_r[i+1];
        end
        reg_num_r[xv_bus_pkg::SYNC_STAGES-1] <= bus_reg_num_i;   // raw pin sample
        data_r[xv_bus_pkg::SYNC_STAGES-1]    <= bus_data_i;
    end

    // fields follow the settled samples, so they line up with the strobe
    always_ff @(posedge clk) begin
        reg_num_o  <= reg_num_r[0];
        bytesel_o  <= bytesel_r[0];
        bytedata_o <= data_r[0];
    end

    // chip select history and strobe generation
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_hist_r      <= 4'b0000;
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
        end else begin
            // fold the active low select into an active high history bit
            cs_hist_r      <= {(bus_cs_n_i == xv_bus_pkg::CS_ENABLED), cs_hist_r[3:1]};
            write_strobe_o <= 1'b0;                 // default idle
            read_strobe_o  <= 1'b0;
            if (cs_rise) begin
                if (read_r[0]) begin
                    read_strobe_o  <= 1'b1;         // host read
                end else begin
                    write_strobe_o <= 1'b1;         // host write
                end
            end
        end
    end

endmodule

/* verilog/reg_block.sv */
`timescale 1ns/1ps

module reg_block (
    input  wire logic [xv_reg_pkg::CMD_W-1:0]         head_i,       // oldest queued command
    input  wire logic                                 empty_i,
    input  wire logic                                 reg_busy_i,   // holds off the write port
    output logic                                      pop_o,        // consume head this cycle
    output logic                                      reg_wr_o,     // word write pulse
    output logic      [xv_bus_pkg::REG_NUM_W-1:0]     reg_addr_o,
    output logic      [xv_reg_pkg::WORD_W-1:0]        reg_wdata_o,
    output logic      [xv_bus_pkg::BYTE_W-1:0]        rd_data_o,    // selected byte of last read
    input  wire logic                                 clk,
    input  wire logic                                 reset_i
);

    // head command fields
    logic                             head_read;     // host read
    logic [xv_bus_pkg::REG_NUM_W-1:0] head_reg;
    logic                             head_odd;      // low byte, commits the word
    logic [xv_bus_pkg::BYTE_W-1:0]    head_data;

    logic [xv_bus_pkg::BYTE_W-1:0]    hi_latch_r;    // high byte of the last even write
    logic [xv_reg_pkg::WORD_W-1:0]    regs_r [xv_reg_pkg::NUM_REGS];
    logic [xv_reg_pkg::WORD_W-1:0]    stored;        // register addressed by the head

    assign head_read = head_i[xv_reg_pkg::CMD_READ_BIT];
    assign head_reg  = head_i[xv_reg_pkg::CMD_REG_LSB +: xv_bus_pkg::REG_NUM_W];
    assign head_odd  = head_i[xv_reg_pkg::CMD_SEL_BIT];
    assign head_data = head_i[xv_reg_pkg::CMD_DATA_LSB +: xv_bus_pkg::BYTE_W];

    assign stored = regs_r[head_reg];

    // only a word write waits for the port
    assign reg_wr_o = !empty_i && !head_read && head_odd && !reg_busy_i;
    assign pop_o    = reg_wr_o || (!empty_i && (head_read || !head_odd));

    // write port, valid while reg_wr_o is high
    assign reg_addr_o  = head_reg;
    assign reg_wdata_o = {hi_latch_r, head_data};   // latched high byte on top

    // latch, register array and read data
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi_latch_r <= '0;
            rd_data_o  <= '0;
            for (int i = 0; i < xv_reg_pkg::NUM_REGS; i++) begin
                regs_r[i] <= '0;
            end
        end else if (pop_o) begin
            if (head_read) begin
                // bytesel 0 picks the high byte
                rd_data_o <= head_odd ? stored[xv_bus_pkg::BYTE_W-1:0]
                                      : stored[xv_reg_pkg::WORD_W-1 -: xv_bus_pkg::BYTE_W];
            end else if (!head_odd) begin
                hi_latch_r <= head_data;            // even byte only latches
            end else begin
                regs_r[head_reg] <= reg_wdata_o;    // whole word, same cycle as the pulse
            end
        end
    end

endmodule

/* verilog/xv_bus_pkg.sv */
package xv_bus_pkg;

    // host side signal levels
    localparam logic CS_ENABLED = 1'b0;    // chip select is active low
    localparam logic RNW_READ   = 1'b1;    // rd_nwr high means a read cycle

    // host bus field widths
    localparam int REG_NUM_W = 4;          // register number, sixteen registers
    localparam int BYTE_W    = 8;          // one data byte per access

    // depth of the data field synchronizers
    // chip select uses its own longer history for edge detection
    localparam int SYNC_STAGES = 2;

endpackage

/* verilog/xv_host_bus.sv */
`timescale 1ns/1ps

module xv_host_bus (
    // host bus, asynchronous to clk
    input  wire logic                                 bus_cs_n_i,
    input  wire logic                                 bus_rd_nwr_i,
    input  wire logic [xv_bus_pkg::REG_NUM_W-1:0]     bus_reg_num_i,
    input  wire logic                                 bus_bytesel_i,
    input  wire logic [xv_bus_pkg::BYTE_W-1:0]        bus_data_i,
    // outgoing register write port
    input  wire logic                                 reg_busy_i,     // holds off reg_wr_o
    output logic                                      reg_wr_o,
    output logic      [xv_bus_pkg::REG_NUM_W-1:0]     reg_addr_o,
    output logic      [xv_reg_pkg::WORD_W-1:0]        reg_wdata_o,
    output logic      [xv_bus_pkg::BYTE_W-1:0]        rd_data_o,      // byte of the last read
    output logic                                      overflow_o,     // sticky, access lost
    input  wire logic                                 clk,
    input  wire logic                                 reset_i
);

    // strobe aligned fields from the bus front end
    logic                             write_strobe;
    logic                             read_strobe;
    logic [xv_bus_pkg::REG_NUM_W-1:0] reg_num;
    logic                             bytesel;
    logic [xv_bus_pkg::BYTE_W-1:0]    bytedata;

    // command queue wiring
    logic                             push;
    logic [xv_reg_pkg::CMD_W-1:0]     cmd;
    logic [xv_reg_pkg::CMD_W-1:0]     head;
    logic                             empty;
    logic                             pop;

    assign push = write_strobe | read_strobe;                   // strobes never overlap
    assign cmd  = {read_strobe, reg_num, bytesel, bytedata};   // read flag on top, data at lsb

    bus_interface u_bus_interface (
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .reg_num_o      (reg_num),
        .bytesel_o      (bytesel),
        .bytedata_o     (bytedata),
        .clk            (clk),
        .reset_i        (reset_i)
    );

    bus_cmd_fifo u_cmd_fifo (
        .push_i      (push),
        .push_data_i (cmd),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (empty),
        .overflow_o  (overflow_o),
        .clk         (clk),
        .reset_i     (reset_i)
    );

    reg_block u_reg_block (
        .head_i      (head),
        .empty_i     (empty),
        .reg_busy_i  (reg_busy_i),
        .pop_o       (pop),
        .reg_wr_o    (reg_wr_o),
        .reg_addr_o  (reg_addr_o),
        .reg_wdata_o (reg_wdata_o),
        .rd_data_o   (rd_data_o),
        .clk         (clk),
        .reset_i     (reset_i)
    );

endmodule

/* verilog/xv_reg_pkg.sv */
package xv_reg_pkg;

    // register set
    localparam int NUM_REGS = 16;          // one per host register number
    localparam int WORD_W   = 16;          // two host bytes per register

    // command word, msb to lsb:
    // read flag, register number, byte select, data byte
    localparam int CMD_W = 1 + xv_bus_pkg::REG_NUM_W + 1 + xv_bus_pkg::BYTE_W;

    localparam int CMD_DATA_LSB = 0;                                       // data byte
    localparam int CMD_SEL_BIT  = CMD_DATA_LSB + xv_bus_pkg::BYTE_W;       // 0 even, 1 odd
    localparam int CMD_REG_LSB  = CMD_SEL_BIT + 1;                         // register number
    localparam int CMD_READ_BIT = CMD_REG_LSB + xv_bus_pkg::REG_NUM_W;     // 1 for reads

    // command queue
    localparam int FIFO_DEPTH = 4;         // power of two, pointers wrap on their own
    localparam int FIFO_PTR_W = 2;         // log2 of FIFO_DEPTH

endpackage

/* xv_host_bus.f */
verilog/xv_bus_pkg.sv
verilog/xv_reg_pkg.sv
verilog/bus_interface.sv
verilog/bus_cmd_fifo.sv
verilog/reg_block.sv
verilog/xv_host_bus.sv
sim/xv_host_bus_checker.sv
sim/xv_host_bus_tb.sv
